// File: bench/cic_mon_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cic_mon_chk
	import cic_pkg::*;
(
	input wire clk,
	input wire arst_n,
	input wire sr_valid,
	input wire ing,
	input wire outg,
	input wire strobe
);

	// cycles in a row that each strobe was high, up to the last edge
	int sr_run;
	int st_run;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sr_run <= 0;
			st_run <= 0;
		end else begin
			sr_run <= sr_valid ? sr_run + 1 : 0;
			st_run <= strobe ? st_run + 1 : 0;
		end
	end

	// a dump burst that ended was one word per channel
	a_sr_len: assert property (@(posedge clk) disable iff (!arst_n)
		(!sr_valid && sr_run != 0) |-> sr_run == NCHAN)
		else $error("sr_valid burst lasted %0d cycles", sr_run);

	// and no dump burst runs past NCHAN words
	a_sr_max: assert property (@(posedge clk) disable iff (!arst_n)
		sr_valid |-> sr_run < NCHAN)
		else $error("sr_valid high for more than NCHAN cycles");

	// half-band latency, product, sum and output registers
	a_hb_lat: assert property (@(posedge clk) disable iff (!arst_n)
		outg == $past(ing, 3))
		else $error("half-band outg does not follow ing by 3 cycles");

	// no result while the design is held in reset
	a_rst: assert property (@(posedge clk) !arst_n |-> !strobe)
		else $error("strobe high during reset");

	// at most one I/Q pair per burst at the output
	a_st_max: assert property (@(posedge clk) disable iff (!arst_n)
		strobe |-> st_run < NCHAN)
		else $error("strobe high for more than NCHAN cycles");

endmodule

bind cic_mon_top cic_mon_chk u_chk (
	.clk      (clk),
	.arst_n   (arst_n),
	.sr_valid (sr_valid),
	.ing      (u_filt.valid_sat),
	.outg     (u_filt.strobe),
	.strobe   (strobe)
);

`default_nettype wire

// File: bench/cic_mon_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cic_mon_tb
	import cic_pkg::*;
();

	// CIC needs three dumps, then the half-band six more words per channel
	localparam int SETTLE_BURSTS = 10;
	localparam int CHECK_BURSTS = 4;
	localparam logic signed [OUT_W-1:0] OUT_MAX = {1'b0, {(OUT_W-1){1'b1}}};
	localparam logic signed [OUT_W-1:0] OUT_MIN = {1'b1, {(OUT_W-1){1'b0}}};

	logic clk;
	logic arst_n;
	logic signed [IN_W-1:0] i_data;
	logic signed [IN_W-1:0] q_data;
	logic [PERIOD_W-1:0] period;
	logic [SHIFT_W-1:0] shift;
	logic signed [OUT_W-1:0] result;
	logic strobe;

	int errors;
	int checks;
	int test_errors;
	int tests_run;
	int tests_failed;
	int wait_limit;
	int dc_i;
	int dc_q;
	logic [31:0] rng;

	cic_mon_top UUT (
		.clk    (clk),
		.arst_n (arst_n),
		.i_data (i_data),
		.q_data (q_data),
		.period (period),
		.shift  (shift),
		.result (result),
		.strobe (strobe)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// small signed DC level, 10 bits keeps period 15 clear of saturation
	task automatic next_level(output int lvl);
		rng = xorshift32(rng);
		lvl = $signed(rng[9:0]);
	endtask

	// gain P squared, shift, then clip and saturate collapse to one clamp
	function automatic logic signed [OUT_W-1:0] dc_model(input int level, input int per,
			input int sh);
		longint p;
		longint v;
		longint hi;
		longint lo;
		p = per + 1;
		hi = (longint'(1) <<< (OUT_W - 1)) - 1;
		lo = -(longint'(1) <<< (OUT_W - 1));
		v = longint'(level) * p * p;
		v = v >>> (sh + SHIFT_BASE);
		if (v > hi)
			v = hi;
		else if (v < lo)
			v = lo;
		return v[OUT_W-1:0];
	endfunction

	task automatic check_result(input string name, input logic signed [OUT_W-1:0] exp,
			input logic signed [OUT_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_strobe(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			test_errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		test_errors++;
		$display("%s", what);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: PASS", name);
		end else begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// one I/Q pair, sampled on the falling edge where the output is stable
	task automatic collect_burst(output logic signed [OUT_W-1:0] i_val,
			output logic signed [OUT_W-1:0] q_val, output bit ok);
		int n;
		ok = 1'b0;
		i_val = '0;
		q_val = '0;
		n = 0;
		@(negedge clk);
		// let a burst already under way go by
		while (strobe && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		n = 0;
		while (!strobe && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!strobe) begin
			report_problem("timed out waiting for strobe to rise");
			return;
		end
		i_val = result;
		@(negedge clk);
		if (!strobe) begin
			report_problem("strobe dropped after the I word, no Q word");
			return;
		end
		q_val = result;
		ok = 1'b1;
	endtask

	// new settings on a rising edge, then skip the transient bursts
	task automatic change_settings(input int per, input int sh, input int ci, input int cq,
			output bit ok);
		int old;
		logic signed [OUT_W-1:0] iv;
		logic signed [OUT_W-1:0] qv;
		old = period;
		@(posedge clk);
		period <= PERIOD_W'(per);
		shift <= SHIFT_W'(sh);
		i_data <= IN_W'(ci);
		q_data <= IN_W'(cq);
		// old period runs out before the new one takes over
		wait_limit = 4 * (((per > old) ? per : old) + 1);
		ok = 1'b1;
		for (int k = 0; k < SETTLE_BURSTS && ok; k++)
			collect_burst(iv, qv, ok);
		wait_limit = 4 * (per + 1);
	endtask

	task automatic test_reset();
		logic signed [OUT_W-1:0] iv;
		logic signed [OUT_W-1:0] qv;
		bit ok;
		for (int k = 0; k < 2; k++) begin
			@(negedge clk);
			check_strobe("strobe", 1'b0, strobe);
		end
		@(posedge clk);
		arst_n <= 1'b1;
		// first wrap only arms the counter, no dump for a full period
		for (int k = 0; k <= period; k++) begin
			@(negedge clk);
			check_strobe("strobe", 1'b0, strobe);
		end
		ok = 1'b1;
		for (int k = 0; k < CHECK_BURSTS && ok; k++) begin
			collect_burst(iv, qv, ok);
			if (ok) begin
				check_result("result(I)", '0, iv);
				check_result("result(Q)", '0, qv);
			end
		end
		finish_test("reset");
	endtask

	task automatic test_dc_gain();
		logic signed [OUT_W-1:0] iv;
		logic signed [OUT_W-1:0] qv;
		bit ok;
		next_level(dc_i);
		next_level(dc_q);
		change_settings(15, 0, dc_i, dc_q, ok);
		for (int k = 0; k < CHECK_BURSTS && ok; k++) begin
			collect_burst(iv, qv, ok);
			if (ok) begin
				check_result("result(I)", dc_model(dc_i, 15, 0), iv);
				check_result("result(Q)", dc_model(dc_q, 15, 0), qv);
			end
		end
		finish_test("dc gain");
	endtask

	task automatic test_shift_scaling();
		logic signed [OUT_W-1:0] iv;
		logic signed [OUT_W-1:0] qv;
		bit ok;
		for (int s = 0; s <= 4; s++) begin
			change_settings(255, s, dc_i, dc_q, ok);
			for (int k = 0; k < 2 && ok; k++) begin
				collect_burst(iv, qv, ok);
				if (ok) begin
					check_result("result(I)", dc_model(dc_i, 255, s), iv);
					check_result("result(Q)", dc_model(dc_q, 255, s), qv);
				end
			end
		end
		finish_test("shift scaling");
	endtask

	task automatic test_saturation();
		logic signed [OUT_W-1:0] iv;
		logic signed [OUT_W-1:0] qv;
		bit ok;
		change_settings(15, 0, 131071, 131071, ok);
		if (ok)
			collect_burst(iv, qv, ok);
		if (ok) begin
			check_result("result(I)", OUT_MAX, iv);
			check_result("result(Q)", OUT_MAX, qv);
		end
		change_settings(15, 0, -131072, -131072, ok);
		if (ok)
			collect_burst(iv, qv, ok);
		if (ok) begin
			check_result("result(I)", OUT_MIN, iv);
			check_result("result(Q)", OUT_MIN, qv);
		end
		finish_test("saturation");
	endtask

	task automatic test_burst_shape();
		int p;
		int n;
		int run;
		int last_rise;
		int bursts;
		logic prev;
		p = period + 1;
		n = 0;
		@(negedge clk);
		while (strobe && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (strobe)
			report_problem("timed out waiting for strobe to fall");
		prev = 1'b0;
		run = 0;
		last_rise = -1;
		bursts = 0;
		// any window of 10 periods holds exactly 10 rising edges
		for (int t = 0; t < 10 * p; t++) begin
			@(negedge clk);
			if (strobe && !prev) begin
				if (last_rise >= 0)
					check_count("strobe spacing", p, t - last_rise);
				last_rise = t;
				bursts++;
			end
			if (strobe) begin
				run++;
			end else if (prev) begin
				check_count("strobe run length", NCHAN, run);
				run = 0;
			end
			prev = strobe;
		end
		check_count("strobe burst count", 10, bursts);
		finish_test("burst shape");
	endtask

	initial begin
		i_data = '0;
		q_data = '0;
		period = PERIOD_W'(15);
		shift = '0;
		arst_n = 1'b0;
		errors = 0;
		checks = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		dc_i = 0;
		dc_q = 0;
		rng = 32'd63108;
		wait_limit = 4 * 16;
		test_reset();
		test_dc_gain();
		test_shift_scaling();
		test_saturation();
		test_burst_shape();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/cc_filt.sv
`timescale 1ns/1ps
`default_nettype none

module cc_filt
	import cic_pkg::*;
(
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire signed [DW-1:0]     sr_in,
	input  wire                     sr_valid,
	input  wire        [SHIFT_W-1:0] shift,
	output logic signed [OUT_W-1:0] result,
	output logic                    strobe
);

	// differentiator output, second difference of the dumps
	logic signed [DW-1:0] d2;
	logic valid2;

	// scaled word before narrowing
	logic [SHIFT_W:0] full_shift;
	logic signed [DW-1:0] d2s;
	logic uniform;

	// clipped to one bit more than the result, then saturated
	logic signed [OUT_W:0] d3;
	logic signed [OUT_W-1:0] d4;
	logic valid_sh;
	logic valid_sat;

	double_diff u_diff (
		.clk    (clk),
		.arst_n (arst_n),
		.d_in   (sr_in),
		.g_in   (sr_valid),
		.d_out  (d2),
		.g_out  (valid2)
	);

	// gain is period squared, shift takes it back down
	assign full_shift = {1'b0, shift} + (SHIFT_W+1)'(SHIFT_BASE);
	assign d2s = d2 >>> full_shift;

	// bits above the clip width all copies of the sign
	assign uniform = (&d2s[DW-1:OUT_W]) | (~|d2s[DW-1:OUT_W]);

	always_ff @(posedge clk) begin
		if (uniform)
			d3 <= d2s[OUT_W:0];
		else
			d3 <= {d2s[DW-1], {OUT_W{~d2s[DW-1]}}};
		// top two bits differ means out of range for OUT_W
		if (d3[OUT_W] == d3[OUT_W-1])
			d4 <= d3[OUT_W-1:0];
		else
			d4 <= {d3[OUT_W], {(OUT_W-1){~d3[OUT_W]}}};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_sh <= 1'b0;
			valid_sat <= 1'b0;
		end else begin
			valid_sh <= valid2;
			valid_sat <= valid_sh;
		end
	end

	// half-band on the interleaved I/Q stream, unity DC gain
	half_band u_hb (
		.clk    (clk),
		.arst_n (arst_n),
		.ind    (d4),
		.ing    (valid_sat),
		.outd   (result),
		.outg   (strobe)
	);

endmodule

`default_nettype wire

// File: hdl/cic_mon_top.sv
`timescale 1ns/1ps
`default_nettype none

module cic_mon_top
	import cic_pkg::*;
(
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire signed [IN_W-1:0]    i_data,
	input  wire signed [IN_W-1:0]    q_data,
	input  wire        [PERIOD_W-1:0] period,
	input  wire        [SHIFT_W-1:0]  shift,
	output logic signed [OUT_W-1:0]  result,
	output logic                     strobe
);

	// interleaved dump burst, I then Q
	logic signed [DW-1:0] sr_data;
	logic sr_valid;

	// integrators and decimation, full clock rate in
	double_integ u_integ (
		.clk      (clk),
		.arst_n   (arst_n),
		.i_data   (i_data),
		.q_data   (q_data),
		.period   (period),
		.sr_data  (sr_data),
		.sr_valid (sr_valid)
	);

	// differentiators, scaling, saturation and half-band
	cc_filt u_filt (
		.clk      (clk),
		.arst_n   (arst_n),
		.sr_in    (sr_data),
		.sr_valid (sr_valid),
		.shift    (shift),
		.result   (result),
		.strobe   (strobe)
	);

endmodule

`default_nettype wire

// File: hdl/cic_pkg.sv
`default_nettype none

package cic_pkg;

	// raw sample width from the mixer, per channel
	localparam int IN_W = 18;

	// period control, decimation period is period + 1 (2 to 256)
	localparam int PERIOD_W = 8;

	// integrator and differentiator word
	// input width plus two bits of growth per octave of period, for order 2
	localparam int DW = IN_W + 2 * PERIOD_W;

	// CIC order, one differentiator stage per integrator
	localparam int CIC_ORDER = 2;

	// result width after scaling and saturation
	localparam int OUT_W = 20;

	// scale control, arithmetic right shift by shift + SHIFT_BASE
	localparam int SHIFT_W = 4;
	localparam int SHIFT_BASE = 0;

	// interleaved channels, 0 is I and 1 is Q
	localparam int NCHAN = 2;
	localparam int CH_W = $clog2(NCHAN);

	// half-band taps, sum is 32 so DC gain is 1 after the shift
	localparam int HB_TAPS = 7;
	localparam int HB_COEF [HB_TAPS] = '{-1, 0, 9, 16, 9, 0, -1};
	localparam int HB_SHIFT = 5;

	// product and accumulator widths inside the half-band
	// largest tap magnitude is 16, sum of magnitudes is 36
	localparam int HB_PROD_W = OUT_W + 5;
	localparam int HB_SUM_W = OUT_W + 6;

endpackage

`default_nettype wire

// File: hdl/double_diff.sv
`timescale 1ns/1ps
`default_nettype none

module double_diff
	import cic_pkg::*;
(
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire signed [DW-1:0]  d_in,
	input  wire                  g_in,
	output logic signed [DW-1:0] d_out,
	output logic                 g_out
);

	// stage inputs, stage 0 takes the burst from the integrator
	logic signed [DW-1:0] st_d [CIC_ORDER];
	logic st_g [CIC_ORDER];

	// stage output registers
	logic signed [DW-1:0] sd [CIC_ORDER];
	logic sg [CIC_ORDER];

	// previous word of each channel, per stage
	logic signed [DW-1:0] hist [CIC_ORDER][NCHAN];

	// position within the burst, which is the channel index
	logic [CH_W-1:0] pos [CIC_ORDER];

	always_comb begin
		st_d[0] = d_in;
		st_g[0] = g_in;
		for (int s = 1; s < CIC_ORDER; s++) begin
			st_d[s] = sd[s-1];
			st_g[s] = sg[s-1];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < CIC_ORDER; s++) begin
				sg[s] <= 1'b0;
				pos[s] <= '0;
				for (int c = 0; c < NCHAN; c++)
					hist[s][c] <= '0;
			end
		end else begin
			for (int s = 0; s < CIC_ORDER; s++) begin
				sg[s] <= st_g[s];
				if (st_g[s]) begin
					hist[s][pos[s]] <= st_d[s];
					pos[s] <= (pos[s] == CH_W'(NCHAN - 1)) ? '0 : pos[s] + 1'b1;
				end else begin
					// gap between bursts, next word is I again
					pos[s] <= '0;
				end
			end
		end
	end

	// word minus the same channel's word one burst earlier
	always_ff @(posedge clk) begin
		for (int s = 0; s < CIC_ORDER; s++) begin
			if (st_g[s])
				sd[s] <= st_d[s] - hist[s][pos[s]];
		end
	end

	assign d_out = sd[CIC_ORDER-1];
	assign g_out = sg[CIC_ORDER-1];

endmodule

`default_nettype wire

// File: hdl/double_integ.sv
`timescale 1ns/1ps
`default_nettype none

module double_integ
	import cic_pkg::*;
(
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire signed [IN_W-1:0]      i_data,
	input  wire signed [IN_W-1:0]      q_data,
	input  wire        [PERIOD_W-1:0]  period,
	output logic signed [DW-1:0]       sr_data,
	output logic                       sr_valid
);

	// channel view of the two inputs
	logic signed [IN_W-1:0] x [NCHAN];

	// first and second integrators, wrap modulo 2**DW
	logic signed [DW-1:0] acc1 [NCHAN];
	logic signed [DW-1:0] acc2 [NCHAN];

	// dump shift register, word 0 leaves first
	logic signed [DW-1:0] sr [NCHAN];

	// period down-counter
	logic [PERIOD_W-1:0] cnt;
	logic wrap;

	// first wrap after reset only starts the count, no dump
	logic armed;
	logic load;

	// words still to leave the dump register
	logic [CH_W:0] left;

	assign x[0] = i_data;
	assign x[1] = q_data;

	assign wrap = (cnt == '0);
	assign load = wrap & armed;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			armed <= 1'b0;
			left <= '0;
			for (int c = 0; c < NCHAN; c++) begin
				acc1[c] <= '0;
				acc2[c] <= '0;
			end
		end else begin
			// reload on wrap, period is only looked at here
			if (wrap) begin
				cnt <= period;
				armed <= 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
			end
			// integrators run every clock, input sign-extended
			for (int c = 0; c < NCHAN; c++) begin
				acc1[c] <= acc1[c] + {{(DW-IN_W){x[c][IN_W-1]}}, x[c]};
				acc2[c] <= acc2[c] + acc1[c];
			end
			// burst length, restarts on every dump
			if (load)
				left <= (CH_W+1)'(NCHAN);
			else if (left != '0)
				left <= left - 1'b1;
		end
	end

	// snapshot of the second integrators, then drain one word per clock
	always_ff @(posedge clk) begin
		if (load) begin
			for (int c = 0; c < NCHAN; c++)
				sr[c] <= acc2[c];
		end else if (left != '0) begin
			for (int c = 0; c < NCHAN - 1; c++)
				sr[c] <= sr[c+1];
		end
	end

	assign sr_data = sr[0];
	assign sr_valid = (left != '0);

endmodule

`default_nettype wire

// File: hdl/half_band.sv
`timescale 1ns/1ps
`default_nettype none

module half_band
	import cic_pkg::*;
(
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire signed [OUT_W-1:0]  ind,
	input  wire                     ing,
	output logic signed [OUT_W-1:0] outd,
	output logic                    outg
);

	// past words of each channel, index 0 is the most recent
	logic signed [OUT_W-1:0] hist [NCHAN][HB_TAPS-1];

	// position within the burst, which is the channel index
	logic [CH_W-1:0] pos;

	// tap inputs, current word then the channel history
	logic signed [OUT_W-1:0] tap [HB_TAPS];

	// product, sum and output stages
	logic signed [HB_PROD_W-1:0] prod [HB_TAPS];
	logic signed [HB_SUM_W-1:0] sum;
	logic signed [HB_SUM_W-1:0] sum_sh;
	logic g1;
	logic g2;

	always_comb begin
		tap[0] = ind;
		for (int t = 1; t < HB_TAPS; t++)
			tap[t] = hist[pos][t-1];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pos <= '0;
			g1 <= 1'b0;
			g2 <= 1'b0;
			outg <= 1'b0;
			for (int c = 0; c < NCHAN; c++)
				for (int t = 0; t < HB_TAPS - 1; t++)
					hist[c][t] <= '0;
		end else begin
			g1 <= ing;
			g2 <= g1;
			outg <= g2;
			if (ing) begin
				hist[pos][0] <= ind;
				for (int t = 1; t < HB_TAPS - 1; t++)
					hist[pos][t] <= hist[pos][t-1];
				pos <= (pos == CH_W'(NCHAN - 1)) ? '0 : pos + 1'b1;
			end else begin
				pos <= '0;
			end
		end
	end

	// round half up, then drop the tap gain
	assign sum_sh = (sum + HB_SUM_W'(1 <<< (HB_SHIFT - 1))) >>> HB_SHIFT;

	always_ff @(posedge clk) begin
		for (int t = 0; t < HB_TAPS; t++)
			prod[t] <= HB_PROD_W'(tap[t]) * HB_PROD_W'(HB_COEF[t]);
		begin
			logic signed [HB_SUM_W-1:0] acc;
			acc = '0;
			for (int t = 0; t < HB_TAPS; t++)
				acc = acc + HB_SUM_W'(prod[t]);
			sum <= acc;
		end
		if (sum_sh > $signed(HB_SUM_W'({1'b0, {(OUT_W-1){1'b1}}})))
			outd <= {1'b0, {(OUT_W-1){1'b1}}};
		else if (sum_sh < -$signed(HB_SUM_W'({1'b0, {(OUT_W-1){1'b1}}})) - 1)
			outd <= {1'b1, {(OUT_W-1){1'b0}}};
		else
			outd <= sum_sh[OUT_W-1:0];
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the CIC monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module cic_mon_tb -f sources.f -o cic_mon_sim

out=$(./obj_dir/cic_mon_sim 2>&1) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF "All tests passed!"; then
	exit 0
else
	exit 1
fi

// File: sources.f
hdl/cic_pkg.sv
hdl/half_band.sv
hdl/double_diff.sv
hdl/cc_filt.sv
hdl/double_integ.sv
hdl/cic_mon_top.sv
bench/cic_mon_chk.sv
bench/cic_mon_tb.sv
